// ==== src/dii_pkg.sv ====
////////////////////////////////////////////////////////////
// Debug interconnect definitions
// Flit format and credit budgets of the debug network
////////////////////////////////////////////////////////////

package dii_pkg;

   // Payload width of one flit
   localparam int DII_FLIT_W = 16;

   // Width of a module id on the network
   localparam int DII_ID_W = 10;

   // Input buffer depth, equal to the credits a sender starts with
   localparam int DII_IN_CREDITS = 8;

   // Credits held for the output port after reset
   localparam int DII_OUT_CREDITS = 4;

   typedef struct packed {
      logic [DII_FLIT_W-1:0] data;
      logic                  last;
   } dii_flit_t;

endpackage

// ==== src/mam_pkg.sv ====
////////////////////////////////////////////////////////////
// Memory access unit definitions
// Request format, Wishbone widths and cycle type codes
////////////////////////////////////////////////////////////

package mam_pkg;

   // Bus geometry
   localparam int MAM_DATA_W = 16;
   localparam int MAM_ADDR_W = 32;
   localparam int MAM_SEL_W  = MAM_DATA_W / 8;

   // Address step between two beats of a burst
   localparam logic [MAM_ADDR_W-1:0] MAM_ADDR_INC = MAM_ADDR_W'(MAM_DATA_W / 8);

   // Control flit layout
   localparam int MAM_BEATS_W     = 14;
   localparam int MAM_CTRL_WE_BIT = 15;

   // Read data buffer between bus master and response encoder
   localparam int MAM_RDBUF_DEPTH = 4;

   // Output credit counter width
   localparam int MAM_OUT_CRED_W = $clog2(dii_pkg::DII_OUT_CREDITS + 1);

   // Wishbone cycle type and burst type codes
   localparam logic [2:0] CTI_CLASSIC    = 3'b000;
   localparam logic [2:0] CTI_INCR       = 3'b010;
   localparam logic [2:0] CTI_END        = 3'b111;
   localparam logic [1:0] MAM_BTE_LINEAR = 2'b00;

   typedef logic [MAM_DATA_W-1:0] mam_word_t;

   // One decoded memory access
   typedef struct packed {
      logic                          we;
      logic [MAM_ADDR_W-1:0]         addr;
      logic [MAM_BEATS_W-1:0]        beats;
      logic [dii_pkg::DII_ID_W-1:0]  id;
   } mam_req_t;

endpackage

// ==== src/dii_credit_fifo.sv ====
////////////////////////////////////////////////////////////
// Credit FIFO
// Circular buffer for any payload, one credit pulse per pop
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dii_credit_fifo #(
   parameter type PAYLOAD_T = logic,
   parameter int  DEPTH     = 4
) (
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  logic     wr_valid_i,
   input  PAYLOAD_T wr_data_i,
   input  logic     rd_ready_i,
   output logic     rd_valid_o,
   output PAYLOAD_T rd_data_o,
   output logic     credit_o,
   output logic     full_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   PAYLOAD_T         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   // Pointers wrap at DEPTH, which need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full_o     = (count == CNT_W'(DEPTH));
   assign rd_valid_o = (count != '0);
   assign rd_data_o  = mem[rd_ptr];

   assign push = wr_valid_i && !full_o;
   assign pop  = rd_valid_o && rd_ready_i;

   // The freed slot is handed back to the sender right away
   assign credit_o = pop;

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_inc(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

endmodule

// ==== src/mam_req_decoder.sv ====
////////////////////////////////////////////////////////////
// MAM request decoder
// Turns request packets into memory accesses and forwards
// the data flits of write requests
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mam_req_decoder
   import dii_pkg::*;
   import mam_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  dii_flit_t             flit_i,
   input  logic                  flit_valid_i,
   input  logic                  req_ready_i,
   input  logic                  wdata_ready_i,
   output logic                  flit_ready_o,
   output mam_req_t              req_o,
   output logic                  req_valid_o,
   output logic [MAM_DATA_W-1:0] wdata_o,
   output logic                  wdata_valid_o
);

   typedef enum logic [2:0] {
      ST_ID,
      ST_CTRL,
      ST_ADDR_HI,
      ST_ADDR_LO,
      ST_REQ,
      ST_WDATA
   } state_t;

   state_t   state_q;
   state_t   state_d;
   mam_req_t req_q;
   logic     flit_pop;

   assign req_o       = req_q;
   assign req_valid_o = (state_q == ST_REQ);

   // Write data goes straight from the input buffer to the bus master
   assign wdata_o       = flit_i.data;
   assign wdata_valid_o = (state_q == ST_WDATA) && flit_valid_i;

   // Hold the input buffer while the master is busy or a request waits for it
   always_comb begin
      case (state_q)
         ST_REQ:   flit_ready_o = 1'b0;
         ST_WDATA: flit_ready_o = wdata_ready_i;
         default:  flit_ready_o = req_ready_i;
      endcase
   end

   assign flit_pop = flit_valid_i && flit_ready_o;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_ID: begin
            if (flit_pop && !flit_i.last) begin
               state_d = ST_CTRL;
            end
         end
         ST_CTRL: begin
            if (flit_pop) begin
               // A packet cut short is dropped
               state_d = flit_i.last ? ST_ID : ST_ADDR_HI;
            end
         end
         ST_ADDR_HI: begin
            if (flit_pop) begin
               state_d = flit_i.last ? ST_ID : ST_ADDR_LO;
            end
         end
         ST_ADDR_LO: begin
            if (flit_pop) begin
               state_d = ST_REQ;
            end
         end
         ST_REQ: begin
            if (req_ready_i) begin
               state_d = req_q.we ? ST_WDATA : ST_ID;
            end
         end
         ST_WDATA: begin
            if (flit_pop && flit_i.last) begin
               state_d = ST_ID;
            end
         end
         default: state_d = ST_ID;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_ID;
      end else begin
         state_q <= state_d;
      end
   end

   // Header fields, collected one flit at a time
   always_ff @(posedge clk_i) begin
      if (flit_pop) begin
         case (state_q)
            ST_ID: begin
               req_q.id <= flit_i.data[DII_ID_W-1:0];
            end
            ST_CTRL: begin
               req_q.we    <= flit_i.data[MAM_CTRL_WE_BIT];
               req_q.beats <= flit_i.data[MAM_BEATS_W-1:0];
            end
            ST_ADDR_HI: begin
               req_q.addr[MAM_ADDR_W-1:MAM_DATA_W] <= flit_i.data;
            end
            ST_ADDR_LO: begin
               req_q.addr[MAM_DATA_W-1:0] <= flit_i.data;
            end
            default: begin
               req_q <= req_q;
            end
         endcase
      end
   end

endmodule

// ==== src/mam_wb_master.sv ====
////////////////////////////////////////////////////////////
// MAM Wishbone master
// Single and incrementing burst cycles for decoded requests
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mam_wb_master
   import mam_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  mam_req_t              req_i,
   input  logic                  req_valid_i,
   input  logic [MAM_DATA_W-1:0] wdata_i,
   input  logic                  wdata_valid_i,
   input  logic                  rbuf_full_i,
   input  logic                  ack_i,
   input  logic [MAM_DATA_W-1:0] dat_i,
   output logic                  req_ready_o,
   output logic                  wdata_ready_o,
   output logic [MAM_DATA_W-1:0] rd_word_o,
   output logic                  rd_word_valid_o,
   output mam_req_t              rsp_req_o,
   output logic                  rsp_start_o,
   output logic                  cyc_o,
   output logic                  stb_o,
   output logic                  we_o,
   output logic [MAM_ADDR_W-1:0] addr_o,
   output logic [MAM_DATA_W-1:0] dat_o,
   output logic [2:0]            cti_o,
   output logic [1:0]            bte_o,
   output logic [MAM_SEL_W-1:0]  sel_o
);

   logic                   busy_q;
   logic                   we_q;
   logic                   burst_q;
   logic [MAM_ADDR_W-1:0]  addr_q;
   logic [MAM_BEATS_W-1:0] beats_left_q;
   logic                   req_accept;
   logic                   beat_ok;
   logic                   beat_done;
   logic                   last_beat;

   assign req_ready_o = !busy_q;
   assign req_accept  = req_valid_i && req_ready_o;

   // A beat starts once its write word is there or the read buffer has room
   assign beat_ok   = we_q ? wdata_valid_i : !rbuf_full_i;
   assign beat_done = stb_o && ack_i;
   assign last_beat = (beats_left_q <= MAM_BEATS_W'(1));

   assign cyc_o  = busy_q;
   assign stb_o  = busy_q && beat_ok;
   assign we_o   = busy_q && we_q;
   assign addr_o = addr_q;
   assign dat_o  = wdata_i;
   assign bte_o  = MAM_BTE_LINEAR;
   assign sel_o  = '1;

   // Write word is popped on ack, read word is pushed on ack
   assign wdata_ready_o   = beat_done && we_q;
   assign rd_word_o       = dat_i;
   assign rd_word_valid_o = beat_done && !we_q;

   always_comb begin
      if (!burst_q) begin
         cti_o = CTI_CLASSIC;
      end else if (last_beat) begin
         cti_o = CTI_END;
      end else begin
         cti_o = CTI_INCR;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         busy_q      <= 1'b0;
         we_q        <= 1'b0;
         burst_q     <= 1'b0;
         rsp_start_o <= 1'b0;
      end else begin
         rsp_start_o <= 1'b0;
         if (req_accept) begin
            busy_q      <= 1'b1;
            we_q        <= req_i.we;
            burst_q     <= (req_i.beats > MAM_BEATS_W'(1));
            rsp_start_o <= !req_i.we;
         end else if (beat_done && last_beat) begin
            busy_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_accept) begin
         addr_q       <= req_i.addr;
         beats_left_q <= req_i.beats;
         rsp_req_o    <= req_i;
      end else if (beat_done) begin
         addr_q       <= addr_q + MAM_ADDR_INC;
         beats_left_q <= beats_left_q - 1'b1;
      end
   end

endmodule

// ==== src/mam_resp_encoder.sv ====
////////////////////////////////////////////////////////////
// MAM response encoder
// Packs read words into response packets under output credits
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mam_resp_encoder
   import dii_pkg::*;
   import mam_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic [DII_ID_W-1:0]   id_i,
   input  mam_req_t              rsp_req_i,
   input  logic                  rsp_start_i,
   input  logic [MAM_DATA_W-1:0] rd_word_i,
   input  logic                  rd_word_valid_i,
   input  logic                  debug_out_credit_i,
   output logic                  rd_word_ready_o,
   output dii_flit_t             debug_out_o,
   output logic                  debug_out_valid_o
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_DEST,
      ST_SRC,
      ST_DATA
   } state_t;

   state_t                  state_q;
   logic [MAM_OUT_CRED_W-1:0] credit_cnt;
   logic                    pend_valid_q;
   mam_req_t                pend_req_q;
   logic [DII_ID_W-1:0]     dest_id_q;
   logic [MAM_BEATS_W-1:0]  words_left_q;
   logic                    have_credit;
   logic                    flit_sent;
   logic                    data_last;

   assign have_credit = (credit_cnt != '0);
   assign flit_sent   = debug_out_valid_o;
   assign data_last   = (words_left_q <= MAM_BEATS_W'(1));

   always_comb begin
      debug_out_o       = '0;
      debug_out_valid_o = 1'b0;
      rd_word_ready_o   = 1'b0;
      case (state_q)
         ST_DEST: begin
            debug_out_o.data  = DII_FLIT_W'(dest_id_q);
            debug_out_valid_o = have_credit;
         end
         ST_SRC: begin
            debug_out_o.data  = DII_FLIT_W'(id_i);
            debug_out_valid_o = have_credit;
         end
         ST_DATA: begin
            debug_out_o.data  = rd_word_i;
            debug_out_o.last  = data_last;
            debug_out_valid_o = have_credit && rd_word_valid_i;
            rd_word_ready_o   = have_credit;
         end
         default: begin
            debug_out_valid_o = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q      <= ST_IDLE;
         credit_cnt   <= MAM_OUT_CRED_W'(DII_OUT_CREDITS);
         pend_valid_q <= 1'b0;
      end else begin
         credit_cnt <= credit_cnt + MAM_OUT_CRED_W'(debug_out_credit_i)
                       - MAM_OUT_CRED_W'(flit_sent);
         case (state_q)
            ST_IDLE: begin
               if (pend_valid_q) begin
                  state_q      <= ST_DEST;
                  pend_valid_q <= 1'b0;
               end
            end
            ST_DEST: begin
               if (flit_sent) begin
                  state_q <= ST_SRC;
               end
            end
            ST_SRC: begin
               if (flit_sent) begin
                  state_q <= ST_DATA;
               end
            end
            default: begin
               if (flit_sent && data_last) begin
                  state_q <= ST_IDLE;
               end
            end
         endcase
         // A read may start while the previous response is still going out
         if (rsp_start_i) begin
            pend_valid_q <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rsp_start_i) begin
         pend_req_q <= rsp_req_i;
      end
      if (state_q == ST_IDLE && pend_valid_q) begin
         dest_id_q    <= pend_req_q.id;
         words_left_q <= pend_req_q.beats;
      end else if (state_q == ST_DATA && flit_sent) begin
         words_left_q <= words_left_q - 1'b1;
      end
   end

endmodule

// ==== src/osd_mam_wb.sv ====
////////////////////////////////////////////////////////////
// Debug memory access unit, Wishbone flavour
// Debug packets in, Wishbone accesses out, read data back
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module osd_mam_wb
   import dii_pkg::*;
   import mam_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  dii_flit_t             debug_in_i,
   input  logic                  debug_in_valid_i,
   output logic                  debug_in_credit_o,
   output dii_flit_t             debug_out_o,
   output logic                  debug_out_valid_o,
   input  logic                  debug_out_credit_i,
   input  logic [DII_ID_W-1:0]   id_i,
   output logic                  cyc_o,
   output logic                  stb_o,
   output logic                  we_o,
   output logic [MAM_ADDR_W-1:0] addr_o,
   output logic [MAM_DATA_W-1:0] dat_o,
   output logic [2:0]            cti_o,
   output logic [1:0]            bte_o,
   output logic [MAM_SEL_W-1:0]  sel_o,
   input  logic                  ack_i,
   input  logic [MAM_DATA_W-1:0] dat_i
);

   dii_flit_t             flit_in;
   logic                  flit_in_valid;
   logic                  flit_in_ready;
   mam_req_t              req;
   logic                  req_valid;
   logic                  req_ready;
   logic [MAM_DATA_W-1:0] wdata;
   logic                  wdata_valid;
   logic                  wdata_ready;
   mam_word_t             rd_word;
   logic                  rd_word_valid;
   logic                  rbuf_full;
   mam_word_t             rbuf_word;
   logic                  rbuf_valid;
   logic                  rbuf_ready;
   mam_req_t              rsp_req;
   logic                  rsp_start;

   // Input flit buffer, its pops return credits to the sender
   dii_credit_fifo #(
      .PAYLOAD_T (dii_flit_t),
      .DEPTH     (DII_IN_CREDITS)
   ) u_in_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wr_valid_i (debug_in_valid_i),
      .wr_data_i  (debug_in_i),
      .rd_ready_i (flit_in_ready),
      .rd_valid_o (flit_in_valid),
      .rd_data_o  (flit_in),
      .credit_o   (debug_in_credit_o),
      .full_o     ()
   );

   mam_req_decoder u_req_decoder (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .flit_i        (flit_in),
      .flit_valid_i  (flit_in_valid),
      .req_ready_i   (req_ready),
      .wdata_ready_i (wdata_ready),
      .flit_ready_o  (flit_in_ready),
      .req_o         (req),
      .req_valid_o   (req_valid),
      .wdata_o       (wdata),
      .wdata_valid_o (wdata_valid)
   );

   mam_wb_master u_wb_master (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .req_i           (req),
      .req_valid_i     (req_valid),
      .wdata_i         (wdata),
      .wdata_valid_i   (wdata_valid),
      .rbuf_full_i     (rbuf_full),
      .ack_i           (ack_i),
      .dat_i           (dat_i),
      .req_ready_o     (req_ready),
      .wdata_ready_o   (wdata_ready),
      .rd_word_o       (rd_word),
      .rd_word_valid_o (rd_word_valid),
      .rsp_req_o       (rsp_req),
      .rsp_start_o     (rsp_start),
      .cyc_o           (cyc_o),
      .stb_o           (stb_o),
      .we_o            (we_o),
      .addr_o          (addr_o),
      .dat_o           (dat_o),
      .cti_o           (cti_o),
      .bte_o           (bte_o),
      .sel_o           (sel_o)
   );

   // Read data buffer
   dii_credit_fifo #(
      .PAYLOAD_T (mam_word_t),
      .DEPTH     (MAM_RDBUF_DEPTH)
   ) u_rd_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wr_valid_i (rd_word_valid),
      .wr_data_i  (rd_word),
      .rd_ready_i (rbuf_ready),
      .rd_valid_o (rbuf_valid),
      .rd_data_o  (rbuf_word),
      .credit_o   (),
      .full_o     (rbuf_full)
   );

   mam_resp_encoder u_resp_encoder (
      .clk_i              (clk_i),
      .rst_n_i            (rst_n_i),
      .id_i               (id_i),
      .rsp_req_i          (rsp_req),
      .rsp_start_i        (rsp_start),
      .rd_word_i          (rbuf_word),
      .rd_word_valid_i    (rbuf_valid),
      .debug_out_credit_i (debug_out_credit_i),
      .rd_word_ready_o    (rbuf_ready),
      .debug_out_o        (debug_out_o),
      .debug_out_valid_o  (debug_out_valid_o)
   );

endmodule

// ==== dv/wb_mem_model.sv ====
////////////////////////////////////////////////////////////
// Wishbone memory model
// Slave memory whose ack delay follows the word address
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module wb_mem_model
   import mam_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic                  cyc_i,
   input  logic                  stb_i,
   input  logic                  we_i,
   input  logic [MAM_ADDR_W-1:0] addr_i,
   input  logic [MAM_DATA_W-1:0] dat_i,
   input  logic [MAM_SEL_W-1:0]  sel_i,
   output logic                  ack_o,
   output logic [MAM_DATA_W-1:0] dat_o
);

   logic [MAM_DATA_W-1:0] mem [1024];
   logic [9:0]            idx;
   logic [1:0]            wait_cnt;
   logic                  respond;

   assign idx = addr_i[10:1];

   // Zero to three wait states per beat, so a burst sees varying delays
   assign respond = cyc_i && stb_i && !ack_o && (wait_cnt == addr_i[2:1]);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o    <= 1'b0;
         wait_cnt <= '0;
      end else if (ack_o) begin
         ack_o    <= 1'b0;
         wait_cnt <= '0;
      end else if (respond) begin
         ack_o <= 1'b1;
      end else if (cyc_i && stb_i) begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (respond && we_i) begin
         for (int b = 0; b < MAM_SEL_W; b++) begin
            if (sel_i[b]) begin
               mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
            end
         end
      end else if (respond) begin
         dat_o <= mem[idx];
      end
   end

endmodule

// ==== dv/osd_mam_wb_sva.sv ====
////////////////////////////////////////////////////////////
// Bus and credit rules of the debug memory access unit
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module osd_mam_wb_sva
   import mam_pkg::*;
(
   input logic                      clk_i,
   input logic                      rst_n_i,
   input logic                      cyc_i,
   input logic                      stb_i,
   input logic                      we_i,
   input logic                      ack_i,
   input logic [MAM_ADDR_W-1:0]     addr_i,
   input logic                      out_valid_i,
   input logic [MAM_OUT_CRED_W-1:0] out_credits_i
);

   int unsigned fail_cnt = 0;

   a_stb_in_cycle: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) stb_i |-> cyc_i
   ) else begin
      fail_cnt++;
      $error("stb_o high outside a bus cycle");
   end

   // A beat keeps its address and direction until the slave acks it
   a_beat_stable: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      stb_i && !ack_i |=> $stable(addr_i) && $stable(we_i)
   ) else begin
      fail_cnt++;
      $error("addr_o or we_o changed before ack_i");
   end

   a_out_credit: assert property (
      @(posedge clk_i) disable iff (!rst_n_i) out_valid_i |-> out_credits_i != '0
   ) else begin
      fail_cnt++;
      $error("debug_out_valid_o with no output credit left");
   end

endmodule

// ==== dv/tb_osd_mam_wb.sv ====
////////////////////////////////////////////////////////////
// Testbench for the debug memory access unit
// Table of write and read packets against a Wishbone memory
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_osd_mam_wb
   import dii_pkg::*;
   import mam_pkg::*;
();

   localparam int CLK_HALF    = 4;
   localparam int RST_CYCLES  = 8;
   localparam int HOLD_CYCLES = 40;
   localparam int IDLE_CYCLES = 4;
   localparam int BEAT_BYTES  = 2;
   localparam int N_TESTS     = 6;
   localparam logic [DII_ID_W-1:0] REQ_ID  = 10'h15c;
   localparam logic [DII_ID_W-1:0] UNIT_ID = 10'h2a7;

   typedef struct {
      string       name;
      logic        we;
      logic [31:0] addr;
      int          beats;
      logic        hold;
   } test_t;

   // Name, write, start address, beats, output credits withheld
   test_t tests [N_TESTS] = '{
      '{"wr_single", 1'b1, 32'h0000_0100, 1, 1'b0},
      '{"rd_single", 1'b0, 32'h0000_0100, 1, 1'b0},
      '{"wr_burst4", 1'b1, 32'h0001_0040, 4, 1'b0},
      '{"rd_burst4", 1'b0, 32'h0001_0040, 4, 1'b0},
      '{"wr_burst8", 1'b1, 32'h0000_0200, 8, 1'b0},
      '{"rd_held8",  1'b0, 32'h0000_0200, 8, 1'b1}
   };

   logic                  clk_i;
   logic                  rst_n_i;
   dii_flit_t             debug_in_i;
   logic                  debug_in_valid_i;
   logic                  debug_in_credit_o;
   dii_flit_t             debug_out_o;
   logic                  debug_out_valid_o;
   logic                  debug_out_credit_i;
   logic [DII_ID_W-1:0]   id_i;
   logic                  cyc_o;
   logic                  stb_o;
   logic                  we_o;
   logic [MAM_ADDR_W-1:0] addr_o;
   logic [MAM_DATA_W-1:0] dat_o;
   logic [2:0]            cti_o;
   logic [1:0]            bte_o;
   logic [MAM_SEL_W-1:0]  sel_o;
   logic                  ack_i;
   logic [MAM_DATA_W-1:0] dat_i;

   logic [31:0] lfsr = 32'h221c_19a9;
   logic [15:0] ref_mem [1024];
   dii_flit_t   tx_q [$];
   dii_flit_t   rx_q [$];
   logic [15:0] wr_words [$];
   string       cur_name = "reset";
   logic [31:0] exp_addr;
   logic        exp_we;
   logic        hold_out;
   int          exp_beats = 0;
   int          beat_cnt = 0;
   int          in_credits = DII_IN_CREDITS;
   int          in_credit_total = 0;
   int          flits_sent = 0;
   int          out_sent = 0;
   int          out_returned = 0;
   int          owed = 0;
   int          checks = 0;
   int          errors = 0;

   osd_mam_wb UUT (.*);

   wb_mem_model u_mem (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .cyc_i   (cyc_o),
      .stb_i   (stb_o),
      .we_i    (we_o),
      .addr_i  (addr_o),
      .dat_i   (dat_o),
      .sel_i   (sel_o),
      .ack_o   (ack_i),
      .dat_o   (dat_i)
   );

   bind osd_mam_wb osd_mam_wb_sva u_sva (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .cyc_i         (cyc_o),
      .stb_i         (stb_o),
      .we_i          (we_o),
      .ack_i         (ack_i),
      .addr_i        (addr_o),
      .out_valid_i   (debug_out_valid_o),
      .out_credits_i (u_resp_encoder.credit_cnt)
   );

   always #CLK_HALF clk_i = ~clk_i;

   function automatic dii_flit_t make_flit(input logic [15:0] data, input logic last);
      dii_flit_t f;
      f.data = data;
      f.last = last;
      return f;
   endfunction

   // Galois LFSR, x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [15:0] next_word();
      logic [15:0] w;
      for (int i = 0; i < 16; i++) begin
         lfsr = lfsr_step(lfsr);
         w[i] = lfsr[0];
      end
      return w;
   endfunction

   function automatic logic [9:0] mem_index(input logic [31:0] a);
      return a[10:1];
   endfunction

   function automatic logic [2:0] expected_cti(input int beat, input int beats);
      if (beats == 1) begin
         return CTI_CLASSIC;
      end
      return (beat == beats - 1) ? CTI_END : CTI_INCR;
   endfunction

   task automatic check_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("** Error %s, %s: expected %h, actual %h", cur_name, what, exp, act);
      end
   endtask

   task automatic check_idle_outputs();
      check_eq("cyc_o", 32'd0, 32'(cyc_o));
      check_eq("stb_o", 32'd0, 32'(stb_o));
      check_eq("we_o", 32'd0, 32'(we_o));
      check_eq("debug_out_valid_o", 32'd0, 32'(debug_out_valid_o));
      check_eq("debug_in_credit_o", 32'd0, 32'(debug_in_credit_o));
   endtask

   // Input port sender, one flit per cycle while credits last
   always @(posedge clk_i) begin
      if (debug_in_credit_o) begin
         in_credits++;
         in_credit_total++;
      end
      if (rst_n_i && tx_q.size() != 0 && in_credits > 0) begin
         debug_in_i       <= tx_q.pop_front();
         debug_in_valid_i <= 1'b1;
         in_credits--;
         flits_sent++;
      end else begin
         debug_in_valid_i <= 1'b0;
      end
   end

   // Output port receiver, returns one credit per flit unless held back
   always @(posedge clk_i) begin
      if (debug_out_valid_o) begin
         rx_q.push_back(debug_out_o);
         out_sent++;
         owed++;
         assert (out_sent <= DII_OUT_CREDITS + out_returned) else begin
            errors++;
            $display("%s: %0d output flits sent on only %0d credits",
                     cur_name, out_sent, DII_OUT_CREDITS + out_returned);
         end
      end
      if (!hold_out && owed > 0) begin
         debug_out_credit_i <= 1'b1;
         owed--;
         out_returned++;
      end else begin
         debug_out_credit_i <= 1'b0;
      end
   end

   // Bus monitor, one check set per acked beat
   always @(posedge clk_i) begin
      if (stb_o && ack_i) begin
         assert (beat_cnt < exp_beats) else begin
            errors++;
            $display("%s: bus beat %0d beyond the %0d requested", cur_name, beat_cnt, exp_beats);
         end
         if (beat_cnt < exp_beats) begin
            check_eq("bus address", exp_addr + 32'(BEAT_BYTES * beat_cnt), addr_o);
            check_eq("bus we", 32'(exp_we), 32'(we_o));
            check_eq("bus cti", 32'(expected_cti(beat_cnt, exp_beats)), 32'(cti_o));
            check_eq("bus sel", 32'({MAM_SEL_W{1'b1}}), 32'(sel_o));
            // Linear burst type
            check_eq("bus bte", 32'd0, 32'(bte_o));
            if (exp_we) begin
               check_eq("bus write data", 32'(wr_words[beat_cnt]), 32'(dat_o));
            end
         end
         beat_cnt++;
      end
   end

   task automatic run_test(input int t);
      logic [15:0] word;
      logic [31:0] a;
      int          beats;
      beats = tests[t].beats;
      @(negedge clk_i);
      cur_name  = tests[t].name;
      exp_addr  = tests[t].addr;
      exp_we    = tests[t].we;
      exp_beats = beats;
      beat_cnt  = 0;
      hold_out  = tests[t].hold;
      rx_q.delete();
      wr_words.delete();
      tx_q.push_back(make_flit(16'(REQ_ID), 1'b0));
      tx_q.push_back(make_flit({tests[t].we, 1'b0, 14'(beats)}, 1'b0));
      tx_q.push_back(make_flit(tests[t].addr[31:16], 1'b0));
      tx_q.push_back(make_flit(tests[t].addr[15:0], !tests[t].we));
      if (tests[t].we) begin
         for (int k = 0; k < beats; k++) begin
            word = next_word();
            a    = tests[t].addr + 32'(BEAT_BYTES * k);
            wr_words.push_back(word);
            ref_mem[mem_index(a)] = word;
            tx_q.push_back(make_flit(word, k == beats - 1));
         end
      end
      if (tests[t].hold) begin
         while (rx_q.size() < DII_OUT_CREDITS) @(negedge clk_i);
         repeat (HOLD_CYCLES) @(negedge clk_i);
         check_eq("flits while credits held", DII_OUT_CREDITS, rx_q.size());
         hold_out = 1'b0;
      end
      while (beat_cnt < beats) @(negedge clk_i);
      if (!tests[t].we) begin
         while (rx_q.size() < beats + 2) @(negedge clk_i);
         check_eq("response dest id", 32'(REQ_ID), 32'(rx_q[0].data));
         check_eq("response src id", 32'(UNIT_ID), 32'(rx_q[1].data));
         check_eq("header last flags", 32'd0, 32'(rx_q[0].last || rx_q[1].last));
         for (int k = 0; k < beats; k++) begin
            a = tests[t].addr + 32'(BEAT_BYTES * k);
            check_eq("read data", 32'(ref_mem[mem_index(a)]), 32'(rx_q[k+2].data));
            check_eq("read last", 32'(k == beats - 1), 32'(rx_q[k+2].last));
         end
      end
      // Input idle, every consumed flit must have come back as a credit
      while (tx_q.size() != 0) @(negedge clk_i);
      repeat (IDLE_CYCLES) @(negedge clk_i);
      check_eq("response length", tests[t].we ? 0 : beats + 2, rx_q.size());
      check_eq("input credits", flits_sent, in_credit_total);
   endtask

   initial begin
      int limit;
      limit = RST_CYCLES;
      foreach (tests[i]) begin
         limit += (tests[i].beats + 8) * 20;
      end
      repeat (limit) @(posedge clk_i);
      $display("Watchdog: the run did not finish within %0d cycles", limit);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      clk_i              = 1'b0;
      rst_n_i            = 1'b0;
      debug_in_i         = '0;
      debug_in_valid_i   = 1'b0;
      debug_out_credit_i = 1'b0;
      id_i               = UNIT_ID;
      hold_out           = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_i);
      check_idle_outputs();
      rst_n_i <= 1'b1;
      repeat (2) @(negedge clk_i);
      check_idle_outputs();
      for (int t = 0; t < N_TESTS; t++) begin
         run_test(t);
      end
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, UUT.u_sva.fail_cnt);
      if (errors == 0 && UUT.u_sva.fail_cnt == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
src/dii_pkg.sv
src/mam_pkg.sv
src/dii_credit_fifo.sv
src/mam_req_decoder.sv
src/mam_wb_master.sv
src/mam_resp_encoder.sv
src/osd_mam_wb.sv
dv/wb_mem_model.sv
dv/osd_mam_wb_sva.sv
dv/tb_osd_mam_wb.sv
